/* include/lc4_defines.svh */
`ifndef LC4_DEFINES_SVH
`define LC4_DEFINES_SVH

// datapath and address width
`define LC4_WORD_W 16

// architectural registers r0..r7
`define LC4_REG_COUNT 8

// first instruction fetched out of reset
`define LC4_RESET_PC 16'h8200

// primary opcodes, insn[15:12]
`define LC4_OPC_ARITH   4'b0001
`define LC4_OPC_LOGIC   4'b0101
`define LC4_OPC_CONST   4'b1001
`define LC4_OPC_SHIFT   4'b1010
`define LC4_OPC_HICONST 4'b1101

`endif

/* logic/lc4_pkg.sv */
`include "lc4_defines.svh"

package lc4_pkg;

    typedef logic [`LC4_WORD_W-1:0] word_t;

    typedef logic [$clog2(`LC4_REG_COUNT)-1:0] reg_idx_t;

    // one-hot n/z/p flags, n in bit 2
    typedef logic [2:0] nzp_t;

    localparam nzp_t NZP_N = 3'b100;
    localparam nzp_t NZP_Z = 3'b010;
    localparam nzp_t NZP_P = 3'b001;

    // ADD and AND also cover the imm5 forms
    typedef enum logic [3:0] {
        NOP,
        ADD,
        MUL,
        SUB,
        AND,
        NOT,
        OR,
        XOR,
        SLL,
        SRA,
        SRL,
        CONST,
        HICONST
    } alu_op_e;

endpackage

/* logic/lc4_regfile.sv */
`timescale 1ns/1ps
`include "lc4_defines.svh"

module lc4_regfile (
    input  logic              gwe,
    input  logic              i_rst_n,
    input  lc4_pkg::reg_idx_t i_rs_sel,
    input  lc4_pkg::reg_idx_t i_rt_sel,
    input  logic              i_wr_we,
    input  lc4_pkg::reg_idx_t i_wr_sel,
    input  lc4_pkg::word_t    i_wr_data,
    output lc4_pkg::word_t    o_rs_data,
    output lc4_pkg::word_t    o_rt_data
);
    import lc4_pkg::*;

    word_t regs [`LC4_REG_COUNT];

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `LC4_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_we) begin
            regs[i_wr_sel] <= i_wr_data;
        end
    end

    // write-through so decode sees a value written back this cycle
    assign o_rs_data = (i_wr_we && i_wr_sel == i_rs_sel) ? i_wr_data : regs[i_rs_sel];
    assign o_rt_data = (i_wr_we && i_wr_sel == i_rt_sel) ? i_wr_data : regs[i_rt_sel];

    a_wr_data_known: assert property (@(posedge gwe) disable iff (!i_rst_n)
        i_wr_we |-> !$isunknown(i_wr_data))
        else $error("regfile write of unknown data to r%0d", i_wr_sel);

endmodule

/* logic/lc4_fetch_decode.sv */
`timescale 1ns/1ps
`include "lc4_defines.svh"

module lc4_fetch_decode (
    input  logic              gwe,
    input  logic              i_rst_n,
    input  lc4_pkg::word_t    i_cur_insn,
    input  logic              i_rf_we,
    input  lc4_pkg::reg_idx_t i_rf_wsel,
    input  lc4_pkg::word_t    i_rf_data,
    output lc4_pkg::word_t    o_cur_pc,
    output lc4_pkg::word_t    o_x_pc,
    output lc4_pkg::word_t    o_x_insn,
    output lc4_pkg::alu_op_e  o_x_op,
    output lc4_pkg::reg_idx_t o_x_rs_sel,
    output lc4_pkg::reg_idx_t o_x_rt_sel,
    output lc4_pkg::reg_idx_t o_x_wsel,
    output logic              o_x_we,
    output lc4_pkg::word_t    o_x_imm,
    output lc4_pkg::word_t    o_x_rs_data,
    output lc4_pkg::word_t    o_x_rt_data
);
    import lc4_pkg::*;

    word_t    d_pc;
    word_t    d_insn;
    alu_op_e  dec_op;
    reg_idx_t dec_rs_sel;
    reg_idx_t dec_rt_sel;
    reg_idx_t dec_wsel;
    logic     dec_we;
    word_t    dec_imm;
    word_t    rs_data;
    word_t    rt_data;

    // fetch pc and decode-stage register, no stalls so both move every edge
    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cur_pc <= `LC4_RESET_PC;
            d_pc     <= '0;
            d_insn   <= '0;
        end else begin
            o_cur_pc <= o_cur_pc + 1'b1;
            d_pc     <= o_cur_pc;
            d_insn   <= i_cur_insn;
        end
    end

    // anything not matched below stays a NOP with no write
    always_comb begin
        dec_op     = NOP;
        dec_we     = 1'b0;
        dec_wsel   = d_insn[11:9];
        dec_rs_sel = d_insn[8:6];
        dec_rt_sel = d_insn[2:0];
        dec_imm    = {{11{d_insn[4]}}, d_insn[4:0]};
        case (d_insn[15:12])
            `LC4_OPC_ARITH: begin
                dec_we = 1'b1;
                casez (d_insn[5:3])
                    3'b000:  dec_op = ADD;
                    3'b001:  dec_op = MUL;
                    3'b010:  dec_op = SUB;
                    3'b1??:  dec_op = ADD;
                    // DIV is not implemented
                    default: dec_we = 1'b0;
                endcase
            end
            `LC4_OPC_LOGIC: begin
                dec_we = 1'b1;
                casez (d_insn[5:3])
                    3'b000:  dec_op = AND;
                    3'b001:  dec_op = NOT;
                    3'b010:  dec_op = OR;
                    3'b011:  dec_op = XOR;
                    default: dec_op = AND;
                endcase
            end
            `LC4_OPC_CONST: begin
                dec_we  = 1'b1;
                dec_op  = CONST;
                dec_imm = {{7{d_insn[8]}}, d_insn[8:0]};
            end
            `LC4_OPC_SHIFT: begin
                dec_we  = 1'b1;
                dec_imm = {12'b0, d_insn[3:0]};
                case (d_insn[5:4])
                    2'b00:   dec_op = SLL;
                    2'b01:   dec_op = SRA;
                    2'b10:   dec_op = SRL;
                    // MOD is not implemented
                    default: dec_we = 1'b0;
                endcase
            end
            `LC4_OPC_HICONST: begin
                // rd is also the source, its low byte survives
                dec_we     = 1'b1;
                dec_op     = HICONST;
                dec_rs_sel = d_insn[11:9];
                dec_imm    = {8'b0, d_insn[7:0]};
            end
            default: begin
                dec_we = 1'b0;
            end
        endcase
    end

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rs_sel  (dec_rs_sel),
        .i_rt_sel  (dec_rt_sel),
        .i_wr_we   (i_rf_we),
        .i_wr_sel  (i_rf_wsel),
        .i_wr_data (i_rf_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    // execute-stage register, control part
    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_x_pc   <= '0;
            o_x_insn <= '0;
            o_x_op   <= NOP;
            o_x_we   <= 1'b0;
        end else begin
            o_x_pc   <= d_pc;
            o_x_insn <= d_insn;
            o_x_op   <= dec_op;
            o_x_we   <= dec_we;
        end
    end

    // execute-stage register, operand part
    always_ff @(posedge gwe) begin
        o_x_rs_sel  <= dec_rs_sel;
        o_x_rt_sel  <= dec_rt_sel;
        o_x_wsel    <= dec_wsel;
        o_x_imm     <= dec_imm;
        o_x_rs_data <= rs_data;
        o_x_rt_data <= rt_data;
    end

    a_pc_step: assert property (@(posedge gwe) disable iff (!i_rst_n)
        $past(i_rst_n) |-> o_cur_pc == $past(o_cur_pc) + 16'd1)
        else $error("pc did not advance by one: %h", o_cur_pc);

endmodule

/* logic/lc4_execute.sv */
`timescale 1ns/1ps

module lc4_execute (
    input  lc4_pkg::word_t    i_x_pc,
    input  lc4_pkg::word_t    i_x_insn,
    input  lc4_pkg::alu_op_e  i_x_op,
    input  lc4_pkg::reg_idx_t i_x_rs_sel,
    input  lc4_pkg::reg_idx_t i_x_rt_sel,
    input  lc4_pkg::reg_idx_t i_x_wsel,
    input  logic              i_x_we,
    input  lc4_pkg::word_t    i_x_imm,
    input  lc4_pkg::word_t    i_x_rs_data,
    input  lc4_pkg::word_t    i_x_rt_data,
    input  logic              i_rf_we,
    input  lc4_pkg::reg_idx_t i_rf_wsel,
    input  lc4_pkg::word_t    i_rf_data,
    output lc4_pkg::word_t    o_m_pc,
    output lc4_pkg::word_t    o_m_insn,
    output lc4_pkg::reg_idx_t o_m_wsel,
    output logic              o_m_we,
    output lc4_pkg::word_t    o_m_result
);
    import lc4_pkg::*;

    word_t      rs_val;
    word_t      rt_val;
    word_t      op_b;
    logic [3:0] shamt;

    // writeback-to-execute bypass, the distance-two case goes through the regfile
    assign rs_val = (i_rf_we && i_rf_wsel == i_x_rs_sel) ? i_rf_data : i_x_rs_data;
    assign rt_val = (i_rf_we && i_rf_wsel == i_x_rt_sel) ? i_rf_data : i_x_rt_data;

    // insn[5] marks the imm5 forms of ADD and AND, it is clear for the other
    // two-operand encodings
    assign op_b  = i_x_insn[5] ? i_x_imm : rt_val;
    assign shamt = i_x_imm[3:0];

    always_comb begin
        case (i_x_op)
            ADD:     o_m_result = rs_val + op_b;
            MUL:     o_m_result = rs_val * op_b;
            SUB:     o_m_result = rs_val - op_b;
            AND:     o_m_result = rs_val & op_b;
            NOT:     o_m_result = ~rs_val;
            OR:      o_m_result = rs_val | op_b;
            XOR:     o_m_result = rs_val ^ op_b;
            SLL:     o_m_result = rs_val << shamt;
            SRA:     o_m_result = $signed(rs_val) >>> shamt;
            SRL:     o_m_result = rs_val >> shamt;
            CONST:   o_m_result = i_x_imm;
            // new high byte over the current low byte of rd
            HICONST: o_m_result = {i_x_imm[7:0], rs_val[7:0]};
            default: o_m_result = '0;
        endcase
    end

    assign o_m_pc   = i_x_pc;
    assign o_m_insn = i_x_insn;
    assign o_m_wsel = i_x_wsel;
    assign o_m_we   = i_x_we;

endmodule

/* logic/lc4_result.sv */
`timescale 1ns/1ps

module lc4_result (
    input  logic              gwe,
    input  logic              i_rst_n,
    input  lc4_pkg::word_t    i_m_pc,
    input  lc4_pkg::word_t    i_m_insn,
    input  lc4_pkg::reg_idx_t i_m_wsel,
    input  logic              i_m_we,
    input  lc4_pkg::word_t    i_m_result,
    output lc4_pkg::word_t    o_wb_pc,
    output lc4_pkg::word_t    o_wb_insn,
    output logic              o_rf_we,
    output lc4_pkg::reg_idx_t o_rf_wsel,
    output lc4_pkg::word_t    o_rf_data,
    output logic              o_nzp_we,
    output lc4_pkg::nzp_t     o_nzp_bits
);
    import lc4_pkg::*;

    // writeback-stage register
    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_pc   <= '0;
            o_wb_insn <= '0;
            o_rf_we   <= 1'b0;
        end else begin
            o_wb_pc   <= i_m_pc;
            o_wb_insn <= i_m_insn;
            o_rf_we   <= i_m_we;
        end
    end

    always_ff @(posedge gwe) begin
        o_rf_wsel <= i_m_wsel;
        o_rf_data <= i_m_result;
    end

    // every register write also sets the flags
    always_comb begin
        if ($signed(o_rf_data) < 0) begin
            o_nzp_bits = NZP_N;
        end else if (o_rf_data == '0) begin
            o_nzp_bits = NZP_Z;
        end else begin
            o_nzp_bits = NZP_P;
        end
    end

    assign o_nzp_we = o_rf_we;

    a_nzp_onehot: assert property (@(posedge gwe) disable iff (!i_rst_n)
        o_nzp_we |-> $onehot(o_nzp_bits))
        else $error("nzp bits not one-hot: %b", o_nzp_bits);

endmodule

/* logic/lc4_core.sv */
`timescale 1ns/1ps

module lc4_core (
    input  logic              gwe,
    input  logic              i_rst_n,
    input  lc4_pkg::word_t    i_cur_insn,
    output lc4_pkg::word_t    o_cur_pc,
    output lc4_pkg::word_t    o_wb_pc,
    output lc4_pkg::word_t    o_wb_insn,
    output logic              o_rf_we,
    output lc4_pkg::reg_idx_t o_rf_wsel,
    output lc4_pkg::word_t    o_rf_data,
    output logic              o_nzp_we,
    output lc4_pkg::nzp_t     o_nzp_bits
);
    import lc4_pkg::*;

    // decode to execute
    word_t    x_pc;
    word_t    x_insn;
    alu_op_e  x_op;
    reg_idx_t x_rs_sel;
    reg_idx_t x_rt_sel;
    reg_idx_t x_wsel;
    logic     x_we;
    word_t    x_imm;
    word_t    x_rs_data;
    word_t    x_rt_data;

    // execute to writeback
    word_t    m_pc;
    word_t    m_insn;
    reg_idx_t m_wsel;
    logic     m_we;
    word_t    m_result;

    lc4_fetch_decode u_fetch_decode (
        .gwe         (gwe),
        .i_rst_n     (i_rst_n),
        .i_cur_insn  (i_cur_insn),
        .i_rf_we     (o_rf_we),
        .i_rf_wsel   (o_rf_wsel),
        .i_rf_data   (o_rf_data),
        .o_cur_pc    (o_cur_pc),
        .o_x_pc      (x_pc),
        .o_x_insn    (x_insn),
        .o_x_op      (x_op),
        .o_x_rs_sel  (x_rs_sel),
        .o_x_rt_sel  (x_rt_sel),
        .o_x_wsel    (x_wsel),
        .o_x_we      (x_we),
        .o_x_imm     (x_imm),
        .o_x_rs_data (x_rs_data),
        .o_x_rt_data (x_rt_data)
    );

    lc4_execute u_execute (
        .i_x_pc      (x_pc),
        .i_x_insn    (x_insn),
        .i_x_op      (x_op),
        .i_x_rs_sel  (x_rs_sel),
        .i_x_rt_sel  (x_rt_sel),
        .i_x_wsel    (x_wsel),
        .i_x_we      (x_we),
        .i_x_imm     (x_imm),
        .i_x_rs_data (x_rs_data),
        .i_x_rt_data (x_rt_data),
        .i_rf_we     (o_rf_we),
        .i_rf_wsel   (o_rf_wsel),
        .i_rf_data   (o_rf_data),
        .o_m_pc      (m_pc),
        .o_m_insn    (m_insn),
        .o_m_wsel    (m_wsel),
        .o_m_we      (m_we),
        .o_m_result  (m_result)
    );

    lc4_result u_result (
        .gwe        (gwe),
        .i_rst_n    (i_rst_n),
        .i_m_pc     (m_pc),
        .i_m_insn   (m_insn),
        .i_m_wsel   (m_wsel),
        .i_m_we     (m_we),
        .i_m_result (m_result),
        .o_wb_pc    (o_wb_pc),
        .o_wb_insn  (o_wb_insn),
        .o_rf_we    (o_rf_we),
        .o_rf_wsel  (o_rf_wsel),
        .o_rf_data  (o_rf_data),
        .o_nzp_we   (o_nzp_we),
        .o_nzp_bits (o_nzp_bits)
    );

endmodule

/* dv/lc4_clock_gen.sv */
`timescale 1ns/1ps

module lc4_clock_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 8
) (
    output logic gwe,
    output logic o_rst_n
);

    initial begin
        gwe = 1'b0;
        forever #(period_ns / 2) gwe = ~gwe;
    end

    // reset drops on a falling edge, away from the capturing edge
    initial begin
        o_rst_n = 1'b0;
        repeat (reset_cycles) @(posedge gwe);
        @(negedge gwe);
        o_rst_n = 1'b1;
    end

endmodule

/* dv/lc4_core_tb.sv */
`timescale 1ns/1ps
`include "lc4_defines.svh"

module lc4_core_tb;
    import lc4_pkg::*;

    localparam int n_insn        = 200;
    localparam int mem_words     = 256;
    localparam int rst_timeout   = 20;
    localparam int trace_timeout = 8;

    logic        gwe;
    logic        rst_n;
    word_t       cur_insn;
    word_t       cur_pc;
    word_t       wb_pc;
    word_t       wb_insn;
    logic        rf_we;
    reg_idx_t    rf_wsel;
    word_t       rf_data;
    logic        nzp_we;
    nzp_t        nzp_bits;

    word_t       imem [mem_words];
    int          fetch_edge [mem_words];
    int          edge_cnt;
    logic [31:0] rng_state;

    // ISA model state and its expected trace
    word_t       model_regs [`LC4_REG_COUNT];
    logic        exp_we [n_insn];
    reg_idx_t    exp_rd [n_insn];
    word_t       exp_val [n_insn];

    int          mismatch_cnt;
    int          fail_cnt;
    logic        timed_out;

    lc4_clock_gen u_clock_gen (
        .gwe     (gwe),
        .o_rst_n (rst_n)
    );

    lc4_core UUT (
        .gwe        (gwe),
        .i_rst_n    (rst_n),
        .i_cur_insn (cur_insn),
        .o_cur_pc   (cur_pc),
        .o_wb_pc    (wb_pc),
        .o_wb_insn  (wb_insn),
        .o_rf_we    (rf_we),
        .o_rf_wsel  (rf_wsel),
        .o_rf_data  (rf_data),
        .o_nzp_we   (nzp_we),
        .o_nzp_bits (nzp_bits)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // registers come from r0..r3 so back-to-back dependences are common
    function automatic word_t make_insn(input logic [31:0] r);
        logic [2:0] rd;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [1:0] sub3;
        rd   = {1'b0, r[1:0]};
        rs   = {1'b0, r[3:2]};
        rt   = {1'b0, r[5:4]};
        sub3 = (r[7:6] == 2'b11) ? 2'b00 : r[7:6];
        if (r[31:29] == 3'b000) begin
            return {4'b0000, 3'b000, r[24:16]};
        end
        case (r[28:26])
            3'd0: return {`LC4_OPC_ARITH, rd, rs, 1'b0, sub3, rt};
            3'd1: return {`LC4_OPC_ARITH, rd, rs, 1'b1, r[20:16]};
            3'd2: return {`LC4_OPC_LOGIC, rd, rs, 1'b0, r[7:6], rt};
            3'd3: return {`LC4_OPC_LOGIC, rd, rs, 1'b1, r[20:16]};
            3'd5: return {`LC4_OPC_SHIFT, rd, rs, sub3, r[19:16]};
            3'd6: return {`LC4_OPC_HICONST, rd, 1'b1, r[23:16]};
            default: return {`LC4_OPC_CONST, rd, r[24:16]};
        endcase
    endfunction

    // one instruction of the ISA, in program order
    task automatic model_step(input word_t insn, output logic we, output reg_idx_t rd,
                              output word_t val);
        word_t a;
        word_t b;
        word_t simm5;
        rd    = insn[11:9];
        a     = model_regs[insn[8:6]];
        b     = model_regs[insn[2:0]];
        simm5 = {{11{insn[4]}}, insn[4:0]};
        we    = 1'b1;
        val   = '0;
        case (insn[15:12])
            `LC4_OPC_ARITH: begin
                if (insn[5]) val = a + simm5;
                else if (insn[4:3] == 2'd0) val = a + b;
                else if (insn[4:3] == 2'd1) val = a * b;
                else if (insn[4:3] == 2'd2) val = a - b;
                else we = 1'b0;
            end
            `LC4_OPC_LOGIC: begin
                if (insn[5]) val = a & simm5;
                else if (insn[4:3] == 2'd0) val = a & b;
                else if (insn[4:3] == 2'd1) val = ~a;
                else if (insn[4:3] == 2'd2) val = a | b;
                else val = a ^ b;
            end
            `LC4_OPC_CONST:   val = {{7{insn[8]}}, insn[8:0]};
            `LC4_OPC_SHIFT: begin
                if (insn[5:4] == 2'd0) val = a << insn[3:0];
                else if (insn[5:4] == 2'd1) val = $signed(a) >>> insn[3:0];
                else if (insn[5:4] == 2'd2) val = a >> insn[3:0];
                else we = 1'b0;
            end
            `LC4_OPC_HICONST: val = {insn[7:0], model_regs[rd][7:0]};
            default:          we = 1'b0;
        endcase
        if (we) model_regs[rd] = val;
    endtask

    function automatic nzp_t nzp_of(input word_t v);
        if (v[15]) return 3'b100;
        if (v == '0) return 3'b010;
        return 3'b001;
    endfunction

    task automatic report_mismatch(input string field, input word_t pc, input word_t got,
                                   input word_t exp);
        mismatch_cnt++;
        $display("Mismatch at %0t: pc %h %s got %0h expected %0h", $time, pc, field, got, exp);
    endtask

    task automatic check_trace_entry(input int i);
        word_t pc;
        pc = `LC4_RESET_PC + i;
        if (edge_cnt != fetch_edge[i] + 3) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: pc %h reached writeback %0d edges after fetch, expected 3",
                     $time, pc, edge_cnt - fetch_edge[i]);
        end
        if (wb_insn !== imem[i]) report_mismatch("o_wb_insn", pc, wb_insn, imem[i]);
        if (rf_we !== exp_we[i]) report_mismatch("o_rf_we", pc, rf_we, exp_we[i]);
        if (nzp_we !== exp_we[i]) report_mismatch("o_nzp_we", pc, nzp_we, exp_we[i]);
        if (exp_we[i]) begin
            if (rf_wsel !== exp_rd[i]) report_mismatch("o_rf_wsel", pc, rf_wsel, exp_rd[i]);
            if (rf_data !== exp_val[i]) report_mismatch("o_rf_data", pc, rf_data, exp_val[i]);
            if (nzp_bits !== nzp_of(exp_val[i])) begin
                report_mismatch("o_nzp_bits", pc, nzp_bits, nzp_of(exp_val[i]));
            end
        end
    endtask

    // instruction memory, presented on the falling edge; also notes when each pc was fetched
    always @(negedge gwe) begin
        if (!$isunknown(cur_pc)) begin
            cur_insn = imem[cur_pc[7:0]];
            fetch_edge[cur_pc[7:0]] = edge_cnt;
        end
    end

    // active rising edges since reset release
    always @(posedge gwe) begin
        if (rst_n) edge_cnt <= edge_cnt + 1;
    end

    initial begin
        int    n;
        logic  found;
        logic  rst_seen;
        word_t pc_exp;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        timed_out    = 1'b0;
        edge_cnt     = 0;
        cur_insn     = '0;
        rng_state    = 32'h16dbdb63;
        for (int a = 0; a < mem_words; a++) begin
            rng_state     = xorshift32(rng_state);
            imem[a]       = make_insn(rng_state);
            fetch_edge[a] = -1;
        end
        for (int r = 0; r < `LC4_REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < n_insn; i++) begin
            model_step(imem[i], exp_we[i], exp_rd[i], exp_val[i]);
        end

        // reset phase, pc parked at the reset address with no writes
        n        = 0;
        rst_seen = 1'b0;
        while (!rst_seen && n < rst_timeout) begin
            @(posedge gwe);
            n++;
            rst_seen = (rst_n === 1'b1);
            if (!rst_seen) begin
                @(negedge gwe);
                if (cur_pc !== `LC4_RESET_PC) begin
                    report_mismatch("o_cur_pc", cur_pc, cur_pc, `LC4_RESET_PC);
                end
                if (rf_we !== 1'b0 || nzp_we !== 1'b0) begin
                    fail_cnt++;
                    $display("write enable high during reset at %0t", $time);
                end
            end
        end
        if (!rst_seen) begin
            timed_out = 1'b1;
            fail_cnt++;
            $display("reset was never released");
        end

        for (int i = 0; i < n_insn && !timed_out; i++) begin
            pc_exp = `LC4_RESET_PC + i;
            found  = 1'b0;
            n      = 0;
            while (!found && n < trace_timeout) begin
                @(negedge gwe);
                n++;
                if (wb_pc === pc_exp) begin
                    found = 1'b1;
                end else if (rf_we !== 1'b0 || nzp_we !== 1'b0) begin
                    fail_cnt++;
                    $display("write enable high at %0t with no instruction in writeback", $time);
                end
            end
            if (!found) begin
                timed_out = 1'b1;
                fail_cnt++;
                $display("timeout at %0t waiting for pc %h in writeback", $time, pc_exp);
            end else begin
                check_trace_entry(i);
            end
        end

        $display("error count: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+include
logic/lc4_pkg.sv
logic/lc4_regfile.sv
logic/lc4_fetch_decode.sv
logic/lc4_execute.sv
logic/lc4_result.sv
logic/lc4_core.sv
dv/lc4_clock_gen.sv
dv/lc4_core_tb.sv
